//--- design/tof_pkg.sv
package tof_pkg;

    // hit code split into two fields
    // upper field picks the coarse bin
    localparam int COARSE_W = 4;

    // lower field picks the fine bin inside one coarse bin
    localparam int FINE_W = 4;

    // full code as it arrives from the TDC
    localparam int CODE_W = COARSE_W + FINE_W;

    // bin index types
    typedef logic [COARSE_W-1:0] coarse_bin_t;
    typedef logic [FINE_W-1:0] fine_bin_t;

    // depth word, window in the upper field, fine peak in the lower field
    typedef logic [CODE_W-1:0] depth_t;

    // per-bin counters
    // coarse bins collect every hit of a frame, so they get more headroom
    typedef logic [11:0] coarse_cnt_t;

    // fine bins only see the hits inside the window
    typedef logic [7:0] fine_cnt_t;

endpackage

//--- design/hit_router.sv
`timescale 1ns/1ps

module hit_router import tof_pkg::*; #(
    parameter int ACQ_NUM = 4,
    parameter int BLANK_CYCLES = 18
) (
    input  logic                clk,
    input  logic                res,
    input  logic                hit,
    input  logic [CODE_W-1:0]   hit_code,
    input  logic                sync,
    input  coarse_bin_t         fine_window,
    output logic                coarse_hit,
    output coarse_bin_t         coarse_bin,
    output logic                fine_hit,
    output fine_bin_t           fine_bin,
    output logic                frame_end
);

    // sync counter range 0 .. ACQ_NUM-1
    localparam int SYNC_W = $clog2(ACQ_NUM + 1);
    // blanking also covers the frame_end cycle itself
    localparam int BLANK_W = $clog2(BLANK_CYCLES + 2);

    logic [SYNC_W-1:0]  sync_cnt;
    logic [BLANK_W-1:0] blank_cnt;
    logic               blanking;
    logic               hit_ok;
    logic               sync_ok;
    logic               last_sync;
    coarse_bin_t        code_hi;
    fine_bin_t          code_lo;

    // dead time after the frame, builders are scanning
    assign blanking  = (blank_cnt != '0);
    assign hit_ok    = hit && !blanking;
    assign sync_ok   = sync && !blanking;
    assign last_sync = sync_ok && (sync_cnt == SYNC_W'(ACQ_NUM - 1));

    // code fields
    assign code_hi = hit_code[CODE_W-1 -: COARSE_W];
    assign code_lo = hit_code[FINE_W-1:0];

    // frame counting and blanking
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sync_cnt  <= '0;
            blank_cnt <= '0;
            frame_end <= 1'b0;
        end else begin
            frame_end <= last_sync;
            if (last_sync) begin
                sync_cnt <= '0;
                // frame_end cycle plus BLANK_CYCLES after it
                blank_cnt <= BLANK_W'(BLANK_CYCLES + 1);
            end else begin
                if (sync_ok) begin
                    sync_cnt <= sync_cnt + 1'b1;
                end
                if (blanking) begin
                    blank_cnt <= blank_cnt - 1'b1;
                end
            end
        end
    end

    // hit strobes, one cycle behind the input
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            coarse_hit <= 1'b0;
            fine_hit   <= 1'b0;
        end else begin
            coarse_hit <= hit_ok;
            // fine side only takes hits in the current window
            fine_hit   <= hit_ok && (code_hi == fine_window);
        end
    end

    // bin indices ride along with the strobes
    always_ff @(posedge clk) begin
        coarse_bin <= code_hi;
        fine_bin   <= code_lo;
    end

endmodule

//--- design/hist_builder.sv
`timescale 1ns/1ps

module hist_builder import tof_pkg::*; #(
    parameter int NBINS = 16,
    parameter type count_t = fine_cnt_t,
    localparam int IDX_W = $clog2(NBINS)
) (
    input  logic                clk,
    input  logic                res,
    input  logic                bin_hit,
    input  logic [IDX_W-1:0]    bin,
    input  logic                frame_end,
    output logic                peak_valid,
    output logic [IDX_W-1:0]    peak_bin,
    output count_t              peak_count
);

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NBINS - 1);

    // one counter per bin
    count_t mem [NBINS];

    // scan state
    logic               scanning;
    logic [IDX_W-1:0]   scan_idx;
    logic [IDX_W-1:0]   best_bin;
    count_t             best_cnt;

    // read side of the increment
    count_t             inc_old;
    count_t             inc_new;

    // read side of the scan
    count_t             scan_cnt;
    logic               scan_take;
    logic [IDX_W-1:0]   next_bin;
    count_t             next_cnt;

    // saturating increment, sticks at the top of count_t
    assign inc_old = mem[bin];
    assign inc_new = (inc_old == '1) ? inc_old : count_t'(inc_old + 1'b1);

    // strictly greater, so on a tie the lower index stays
    assign scan_cnt  = mem[scan_idx];
    assign scan_take = (scan_cnt > best_cnt);
    assign next_bin  = scan_take ? scan_idx : best_bin;
    assign next_cnt  = scan_take ? scan_cnt : best_cnt;

    // bin memory, increment outside the scan, clear during it
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < NBINS; i++) begin
                mem[i] <= '0;
            end
        end else if (scanning) begin
            // read-and-clear, one bin per cycle
            mem[scan_idx] <= '0;
        end else if (bin_hit) begin
            mem[bin] <= inc_new;
        end
    end

    // scan control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning   <= 1'b0;
            scan_idx   <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= 1'b0;
            if (scanning) begin
                if (scan_idx == LAST_IDX) begin
                    scanning   <= 1'b0;
                    scan_idx   <= '0;
                    peak_valid <= 1'b1;
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                end
            end else if (frame_end) begin
                // start at bin 0 on the next cycle
                scanning <= 1'b1;
                scan_idx <= '0;
            end
        end
    end

    // running maximum
    // empty histogram falls out as bin 0 count 0
    always_ff @(posedge clk) begin
        if (frame_end && !scanning) begin
            best_bin <= '0;
            best_cnt <= '0;
        end else if (scanning) begin
            best_bin <= next_bin;
            best_cnt <= next_cnt;
        end
    end

    // peak report, last compare folded in
    always_ff @(posedge clk) begin
        if (scanning && (scan_idx == LAST_IDX)) begin
            peak_bin   <= next_bin;
            peak_count <= next_cnt;
        end
    end

endmodule

//--- design/depth_combiner.sv
`timescale 1ns/1ps

module depth_combiner import tof_pkg::*; (
    input  logic            clk,
    input  logic            res,
    input  logic            coarse_valid_in,
    input  coarse_bin_t     coarse_bin_in,
    input  coarse_cnt_t     coarse_cnt_in,
    input  logic            fine_valid_in,
    input  fine_bin_t       fine_bin_in,
    input  fine_cnt_t       fine_cnt_in,
    output coarse_bin_t     fine_window,
    output logic            coarse_valid,
    output coarse_bin_t     coarse_peak,
    output coarse_cnt_t     coarse_count,
    output logic            depth_valid,
    output depth_t          depth,
    output fine_cnt_t       fine_count
);

    // pending flags, one per report
    logic           c_pend;
    logic           f_pend;
    logic           both;

    // held reports
    coarse_bin_t    c_bin_q;
    coarse_cnt_t    c_cnt_q;
    fine_bin_t      f_bin_q;
    fine_cnt_t      f_cnt_q;

    assign both = c_pend && f_pend;

    // control, flags and window
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            c_pend       <= 1'b0;
            f_pend       <= 1'b0;
            coarse_valid <= 1'b0;
            depth_valid  <= 1'b0;
            fine_window  <= '0;
        end else begin
            coarse_valid <= both;
            depth_valid  <= both;
            if (both) begin
                c_pend <= 1'b0;
                f_pend <= 1'b0;
                // next frame looks around the new coarse peak
                fine_window <= c_bin_q;
            end
            // new report wins over the clear
            if (coarse_valid_in) begin
                c_pend <= 1'b1;
            end
            if (fine_valid_in) begin
                f_pend <= 1'b1;
            end
        end
    end

    // report capture
    always_ff @(posedge clk) begin
        if (coarse_valid_in) begin
            c_bin_q <= coarse_bin_in;
            c_cnt_q <= coarse_cnt_in;
        end
        if (fine_valid_in) begin
            f_bin_q <= fine_bin_in;
            f_cnt_q <= fine_cnt_in;
        end
    end

    // outputs, window is still the one of the finished frame here
    always_ff @(posedge clk) begin
        if (both) begin
            coarse_peak  <= c_bin_q;
            coarse_count <= c_cnt_q;
            depth        <= {fine_window, f_bin_q};
            fine_count   <= f_cnt_q;
        end
    end

endmodule

//--- design/tof_histogram_top.sv
`timescale 1ns/1ps

module tof_histogram_top import tof_pkg::*; #(
    parameter int ACQ_NUM = 4
) (
    input  logic                clk,
    input  logic                res,
    input  logic                hit,
    input  logic [CODE_W-1:0]   hit_code,
    input  logic                sync,
    output logic                coarse_valid,
    output coarse_bin_t         coarse_peak,
    output coarse_cnt_t         coarse_count,
    output logic                depth_valid,
    output depth_t              depth,
    output fine_cnt_t           fine_count
);

    // bin counts follow the code fields
    localparam int NBINS_C = 2 ** COARSE_W;
    localparam int NBINS_F = 2 ** FINE_W;
    // dead time covers the longer scan plus report
    localparam int BLANK_CYCLES = ((NBINS_C > NBINS_F) ? NBINS_C : NBINS_F) + 2;

    // router to builders
    logic           coarse_hit;
    coarse_bin_t    coarse_bin;
    logic           fine_hit;
    fine_bin_t      fine_bin;
    logic           frame_end;

    // builders to combiner
    logic           c_peak_valid;
    coarse_bin_t    c_peak_bin;
    coarse_cnt_t    c_peak_count;
    logic           f_peak_valid;
    fine_bin_t      f_peak_bin;
    fine_cnt_t      f_peak_count;

    // combiner back to router
    coarse_bin_t    fine_window;

    hit_router #(
        .ACQ_NUM      (ACQ_NUM),
        .BLANK_CYCLES (BLANK_CYCLES)
    ) i_hit_router (
        .clk         (clk),
        .res         (res),
        .hit         (hit),
        .hit_code    (hit_code),
        .sync        (sync),
        .fine_window (fine_window),
        .coarse_hit  (coarse_hit),
        .coarse_bin  (coarse_bin),
        .fine_hit    (fine_hit),
        .fine_bin    (fine_bin),
        .frame_end   (frame_end)
    );

    // coarse histogram, wide counters
    hist_builder #(
        .NBINS   (NBINS_C),
        .count_t (coarse_cnt_t)
    ) i_coarse_hist (
        .clk        (clk),
        .res        (res),
        .bin_hit    (coarse_hit),
        .bin        (coarse_bin),
        .frame_end  (frame_end),
        .peak_valid (c_peak_valid),
        .peak_bin   (c_peak_bin),
        .peak_count (c_peak_count)
    );

    // fine histogram, windowed hits only
    hist_builder #(
        .NBINS   (NBINS_F),
        .count_t (fine_cnt_t)
    ) i_fine_hist (
        .clk        (clk),
        .res        (res),
        .bin_hit    (fine_hit),
        .bin        (fine_bin),
        .frame_end  (frame_end),
        .peak_valid (f_peak_valid),
        .peak_bin   (f_peak_bin),
        .peak_count (f_peak_count)
    );

    depth_combiner i_depth_combiner (
        .clk             (clk),
        .res             (res),
        .coarse_valid_in (c_peak_valid),
        .coarse_bin_in   (c_peak_bin),
        .coarse_cnt_in   (c_peak_count),
        .fine_valid_in   (f_peak_valid),
        .fine_bin_in     (f_peak_bin),
        .fine_cnt_in     (f_peak_count),
        .fine_window     (fine_window),
        .coarse_valid    (coarse_valid),
        .coarse_peak     (coarse_peak),
        .coarse_count    (coarse_count),
        .depth_valid     (depth_valid),
        .depth           (depth),
        .fine_count      (fine_count)
    );

endmodule

//--- tb/tb_tof_histogram.sv
`timescale 1ns/1ps

module tb_tof_histogram import tof_pkg::*; ();

    localparam int ACQ_NUM = 4;
    localparam int NC = 2 ** COARSE_W;
    localparam int NF = 2 ** FINE_W;
    localparam logic [31:0] SEED = 32'h9115_1900;
    // about 750 cycles of tests, doubled
    localparam int TIMEOUT_CYCLES = 1500;
    // scan plus combiner latency is about 20 cycles
    localparam int RESULT_WAIT = 40;

    logic           clk;
    logic           res;
    logic           hit;
    logic [CODE_W-1:0] hit_code;
    logic           sync;
    logic           coarse_valid;
    coarse_bin_t    coarse_peak;
    coarse_cnt_t    coarse_count;
    logic           depth_valid;
    depth_t         depth;
    fine_cnt_t      fine_count;

    // reference histograms of the frame in progress
    int             c_model [NC];
    int             f_model [NF];
    coarse_bin_t    win_model;

    int             val_errs = 0;
    int             proto_errs = 0;
    int             cycles = 0;

    tof_histogram_top #(
        .ACQ_NUM (ACQ_NUM)
    ) i_tof_histogram_top (
        .clk          (clk),
        .res          (res),
        .hit          (hit),
        .hit_code     (hit_code),
        .sync         (sync),
        .coarse_valid (coarse_valid),
        .coarse_peak  (coarse_peak),
        .coarse_count (coarse_count),
        .depth_valid  (depth_valid),
        .depth        (depth),
        .fine_count   (fine_count)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // one cycle of stimulus, applied on the rising edge
    task automatic drive(input logic h, input logic [CODE_W-1:0] code, input logic s);
        @(posedge clk);
        hit      <= h;
        hit_code <= code;
        sync     <= s;
    endtask

    task automatic idle();
        drive(1'b0, '0, 1'b0);
    endtask

    task automatic clear_model();
        for (int i = 0; i < NC; i++) begin
            c_model[i] = 0;
        end
        for (int i = 0; i < NF; i++) begin
            f_model[i] = 0;
        end
    endtask

    // counted hit, model saturates like the bins
    task automatic send_hit(input logic [CODE_W-1:0] code);
        coarse_bin_t hi;
        fine_bin_t   lo;
        hi = code[CODE_W-1 -: COARSE_W];
        lo = code[FINE_W-1:0];
        if (c_model[hi] < 4095) begin
            c_model[hi]++;
        end
        // fine side only inside the window
        if (hi == win_model && f_model[lo] < 255) begin
            f_model[lo]++;
        end
        drive(1'b1, code, 1'b0);
    endtask

    task automatic pulse_sync(input logic with_hit, input logic [CODE_W-1:0] code);
        if (with_hit) begin
            send_hit(code);
            // same cycle as the hit
            sync <= 1'b1;
        end else begin
            drive(1'b0, '0, 1'b1);
        end
        idle();
    endtask

    // ACQ_NUM syncs, optional hit on the completing one
    task automatic close_frame(input logic with_hit, input logic [CODE_W-1:0] code);
        for (int i = 0; i < ACQ_NUM - 1; i++) begin
            pulse_sync(1'b0, '0);
        end
        pulse_sync(with_hit, code);
    endtask

    task automatic watch_quiet(input int n, input string tag);
        bit seen;
        seen = 1'b0;
        repeat (n) begin
            @(negedge clk);
            if (coarse_valid || depth_valid) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            proto_errs++;
            $display("%s: a result strobe pulsed where none was expected", tag);
        end
    endtask

    // wait for the frame report and compare it with the model
    task automatic collect_result(input string tag);
        int n = 0;
        int c_bin = 0;
        int c_cnt = 0;
        int f_bin = 0;
        int f_cnt = 0;
        // highest count, lowest index on a tie
        for (int i = 0; i < NC; i++) begin
            if (c_model[i] > c_cnt) begin
                c_bin = i;
                c_cnt = c_model[i];
            end
        end
        for (int i = 0; i < NF; i++) begin
            if (f_model[i] > f_cnt) begin
                f_bin = i;
                f_cnt = f_model[i];
            end
        end
        do begin
            @(negedge clk);
            n++;
        end while (!depth_valid && n < RESULT_WAIT);
        if (!depth_valid) begin
            proto_errs++;
            $display("%s: no depth_valid strobe within %0d cycles", tag, RESULT_WAIT);
        end else begin
            if (!coarse_valid) begin
                proto_errs++;
                $display("%s: coarse_valid did not pulse with depth_valid", tag);
            end
            check(32'(coarse_peak), c_bin, {tag, " coarse_peak"});
            check(32'(coarse_count), c_cnt, {tag, " coarse_count"});
            // window of the finished frame above the fine peak
            check(32'(depth), int'(win_model) * NF + f_bin, {tag, " depth"});
            check(32'(fine_count), f_cnt, {tag, " fine_count"});
        end
        win_model = coarse_bin_t'(c_bin);
        clear_model();
    endtask

    task automatic test_reset_quiet();
        watch_quiet(50, "idle after reset");
    endtask

    task automatic test_first_frame();
        // cluster in coarse bin 5
        for (int i = 0; i < 20; i++) begin
            send_hit({4'h5, fine_bin_t'($urandom)});
        end
        // window is 0 in the first frame
        for (int i = 0; i < 8; i++) begin
            send_hit({4'h0, fine_bin_t'($urandom)});
        end
        for (int i = 0; i < 5; i++) begin
            send_hit(CODE_W'($urandom));
        end
        idle();
        close_frame(1'b0, '0);
        collect_result("first frame");
    endtask

    task automatic test_second_frame();
        for (int i = 0; i < 30; i++) begin
            send_hit({win_model, fine_bin_t'($urandom)});
        end
        for (int i = 0; i < 10; i++) begin
            send_hit(CODE_W'($urandom));
        end
        idle();
        // hit on the completing sync still counts
        close_frame(1'b1, {win_model, 4'hC});
        collect_result("second frame");
    endtask

    task automatic test_tie_and_empty();
        for (int i = 0; i < 7; i++) begin
            send_hit(8'h92);
            send_hit(8'h37);
        end
        idle();
        close_frame(1'b0, '0);
        collect_result("coarse tie");
        close_frame(1'b0, '0);
        collect_result("empty frame");
    endtask

    task automatic test_saturation();
        // 300 hits on one fine bin, fine count stops at 255
        for (int i = 0; i < 300; i++) begin
            send_hit({win_model, 4'hA});
        end
        idle();
        close_frame(1'b0, '0);
        collect_result("fine saturation");
    endtask

    task automatic test_blanking();
        for (int i = 0; i < 10; i++) begin
            send_hit(8'h27);
        end
        for (int i = 0; i < 4; i++) begin
            send_hit(8'h03);
        end
        idle();
        close_frame(1'b0, '0);
        // dead time through the scan and past its end, none of this may land
        // upper field 2 is the next window, so a leak would show in fine_count
        for (int i = 0; i < 16; i++) begin
            drive(1'b1, 8'h2E, 1'b0);
        end
        drive(1'b0, '0, 1'b1);
        idle();
        collect_result("blanking frame");
        for (int i = 0; i < 5; i++) begin
            send_hit(8'h45);
        end
        idle();
        // dropped sync must not shorten this frame
        for (int i = 0; i < ACQ_NUM - 1; i++) begin
            pulse_sync(1'b0, '0);
        end
        watch_quiet(RESULT_WAIT, "frame one sync short");
        pulse_sync(1'b0, '0);
        collect_result("after blanking");
    endtask

    initial begin
        res      = 1'b0;
        hit      = 1'b0;
        hit_code = '0;
        sync     = 1'b0;
        void'($urandom(SEED));
        win_model = '0;
        clear_model();
        repeat (5) @(posedge clk);
        res <= 1'b1;
        test_reset_quiet();
        test_first_frame();
        test_second_frame();
        test_tie_and_empty();
        test_saturation();
        test_blanking();
        $display("errors: %0d value mismatches, %0d protocol failures", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
design/tof_pkg.sv
design/hit_router.sv
design/hist_builder.sv
design/depth_combiner.sv
design/tof_histogram_top.sv
tb/tb_tof_histogram.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0 --Mdir obj_dir
TOP       = tb_tof_histogram
FILELIST  = build.f
SIM_BIN   = obj_dir/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
